// ==== design/rob_pkg.sv ====
/*
  shared widths, vector types and code enums for the reorder buffer
  major opcode, destination kind and execution route encodings
*/
package rob_pkg;

    localparam int XLEN      = 32;
    localparam int ROB_TAG_W = 4;

    typedef logic [XLEN-1:0]      word_t;     // pc, immediate, result
    typedef logic [4:0]           reg_idx_t;  // architectural register
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;  // tag is the slot index
    typedef logic [2:0]           funct3_t;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } op_major_e;

    // what an entry writes when it commits
    typedef enum logic [1:0] {
        dest_mem       = 2'd0,
        dest_reg       = 2'd1,
        dest_branch    = 2'd2,
        dest_jump_link = 2'd3
    } dest_kind_e;

    typedef enum logic [1:0] {
        route_lsu    = 2'd0,  // load/store buffer
        route_alu    = 2'd1,  // reservation station
        route_branch = 2'd2   // branch unit, jumps included
    } route_e;

endpackage

// ==== design/rob_classify.sv ====
/*
  opcode classifier for new allocations
  gives destination kind, execution route and jump flag
  LUI and AUIPC finish here with their value
*/
module rob_classify import rob_pkg::*; (
    input  op_major_e  op,
    input  word_t      pc,
    input  word_t      imm,
    output dest_kind_e kind,
    output route_e     route,
    output logic       is_jump,
    output logic       early_done,
    output word_t      early_value
);

    always_comb begin
        kind        = dest_reg;   // unknown opcodes behave as ALU writes
        route       = route_alu;
        is_jump     = 1'b0;
        early_done  = 1'b0;
        early_value = imm;
        case (op)
            op_lui: begin
                early_done = 1'b1;
            end
            op_auipc: begin
                early_done  = 1'b1;
                early_value = pc + imm;
            end
            op_jal, op_jalr: begin
                kind    = dest_jump_link;
                route   = route_branch;
                is_jump = 1'b1;
            end
            op_branch: begin
                kind  = dest_branch;
                route = route_branch;
            end
            op_load, op_store: begin
                kind  = dest_mem;  // loads share the memory kind
                route = route_lsu;
            end
            default: ;
        endcase
    end

endmodule

// ==== design/rob_entry_store.sv ====
/*
  circular entry storage of the reorder buffer
  head/tail pointers, occupancy count, valid/issued/done flags
  read ports for the issue selector and the commit head, tag writeback
*/
module rob_entry_store import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                 clk_in,
    input  logic                 rst_n,
    // allocation
    input  logic                 alloc_valid,
    output logic                 alloc_ready,
    input  op_major_e            alloc_op,
    input  funct3_t              alloc_funct3,
    input  logic                 alloc_funct7_alt,
    input  word_t                alloc_pc,
    input  reg_idx_t             alloc_rd, alloc_rs1, alloc_rs2,
    input  word_t                alloc_imm,
    input  dest_kind_e           kind,
    input  route_e               route,
    input  logic                 is_jump,
    input  logic                 early_done,
    input  word_t                early_value,
    // issue selection
    output logic [ROB_DEPTH-1:0] pending_mask,
    output rob_tag_t             head_ptr,
    input  rob_tag_t             sel_tag,
    input  logic                 issue_take,
    output op_major_e            sel_op,
    output funct3_t              sel_funct3,
    output logic                 sel_funct7_alt,
    output word_t                sel_pc,
    output reg_idx_t             sel_rd, sel_rs1, sel_rs2,
    output word_t                sel_imm,
    output route_e               sel_route,
    output logic                 sel_is_jump,
    // writeback
    input  logic                 wb_valid,
    input  rob_tag_t             wb_tag,
    input  word_t                wb_value,
    input  logic                 wb_pc_change,
    input  word_t                wb_new_pc,
    // commit head
    output logic                 head_done,
    output rob_tag_t             head_tag,
    output dest_kind_e           head_kind,
    output reg_idx_t             head_rd,
    output word_t                head_value,
    output logic                 head_pc_change,
    output word_t                head_new_pc,
    input  logic                 commit_take
);

    op_major_e  op_q [ROB_DEPTH];
    funct3_t    funct3_q [ROB_DEPTH];
    logic       funct7_alt_q [ROB_DEPTH];
    word_t      pc_q [ROB_DEPTH];
    reg_idx_t   rd_q [ROB_DEPTH];
    reg_idx_t   rs1_q [ROB_DEPTH];
    reg_idx_t   rs2_q [ROB_DEPTH];
    word_t      imm_q [ROB_DEPTH];
    dest_kind_e kind_q [ROB_DEPTH];
    route_e     route_q [ROB_DEPTH];
    logic       is_jump_q [ROB_DEPTH];
    word_t      value_q [ROB_DEPTH];
    logic       pc_change_q [ROB_DEPTH];
    word_t      new_pc_q [ROB_DEPTH];

    logic [ROB_DEPTH-1:0] valid_q, issued_q, done_q;
    rob_tag_t             tail_ptr;
    logic [ROB_TAG_W:0]   count;      // one bit wider, holds ROB_DEPTH
    logic                 alloc_fire;
    logic                 redirect_kind;

    function automatic rob_tag_t ptr_next(input rob_tag_t p);
        if (p == rob_tag_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign alloc_ready  = (count < ROB_DEPTH);
    assign alloc_fire   = alloc_valid & alloc_ready;
    assign pending_mask = valid_q & ~issued_q;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            issued_q <= '0;
            done_q   <= '0;
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else begin
            if (alloc_fire) begin
                valid_q[tail_ptr]  <= 1'b1;
                issued_q[tail_ptr] <= early_done;  // never goes to a unit
                done_q[tail_ptr]   <= early_done;
                tail_ptr           <= ptr_next(tail_ptr);
            end
            if (issue_take) issued_q[sel_tag] <= 1'b1;
            if (wb_valid) done_q[wb_tag] <= 1'b1;
            if (commit_take) begin
                valid_q[head_ptr] <= 1'b0;
                head_ptr          <= ptr_next(head_ptr);
            end
            if (alloc_fire && !commit_take) begin
                count <= count + 1'b1;
            end else if (!alloc_fire && commit_take) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc_fire) begin
            op_q[tail_ptr]         <= alloc_op;
            funct3_q[tail_ptr]     <= alloc_funct3;
            funct7_alt_q[tail_ptr] <= alloc_funct7_alt;
            pc_q[tail_ptr]         <= alloc_pc;
            rd_q[tail_ptr]         <= alloc_rd;
            rs1_q[tail_ptr]        <= alloc_rs1;
            rs2_q[tail_ptr]        <= alloc_rs2;
            imm_q[tail_ptr]        <= alloc_imm;
            kind_q[tail_ptr]       <= kind;
            route_q[tail_ptr]      <= route;
            is_jump_q[tail_ptr]    <= is_jump;
            value_q[tail_ptr]      <= early_value;
            pc_change_q[tail_ptr]  <= 1'b0;
        end
        if (wb_valid) begin
            value_q[wb_tag]     <= wb_value;
            pc_change_q[wb_tag] <= wb_pc_change;
            new_pc_q[wb_tag]    <= wb_new_pc;
        end
    end

    assign sel_op         = op_q[sel_tag];
    assign sel_funct3     = funct3_q[sel_tag];
    assign sel_funct7_alt = funct7_alt_q[sel_tag];
    assign sel_pc         = pc_q[sel_tag];
    assign sel_rd         = rd_q[sel_tag];
    assign sel_rs1        = rs1_q[sel_tag];
    assign sel_rs2        = rs2_q[sel_tag];
    assign sel_imm        = imm_q[sel_tag];
    assign sel_route      = route_q[sel_tag];
    assign sel_is_jump    = is_jump_q[sel_tag];

    // only branches and jumps may redirect fetch
    assign redirect_kind  = (kind_q[head_ptr] == dest_branch) ||
                            (kind_q[head_ptr] == dest_jump_link);
    assign head_done      = valid_q[head_ptr] & done_q[head_ptr];
    assign head_tag       = head_ptr;
    assign head_kind      = kind_q[head_ptr];
    assign head_rd        = rd_q[head_ptr];
    assign head_value     = value_q[head_ptr];
    assign head_pc_change = redirect_kind & pc_change_q[head_ptr];
    assign head_new_pc    = head_pc_change ? new_pc_q[head_ptr] : pc_q[head_ptr];

endmodule

// ==== design/rob_issue_select.sv ====
/*
  oldest-first issue selection and the issue output register
*/
module rob_issue_select import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  logic [ROB_DEPTH-1:0] pending_mask,
    input  rob_tag_t             head_ptr,
    input  op_major_e            sel_op,
    input  funct3_t              sel_funct3,
    input  logic                 sel_funct7_alt,
    input  word_t                sel_pc,
    input  reg_idx_t             sel_rd, sel_rs1, sel_rs2,
    input  word_t                sel_imm,
    input  route_e               sel_route,
    input  logic                 sel_is_jump,
    output rob_tag_t             sel_tag,
    output logic                 issue_take,
    output logic                 issue_valid,
    input  logic                 issue_ready,
    output rob_tag_t             issue_tag,
    output route_e               issue_route,
    output logic                 issue_is_jump,
    output op_major_e            issue_op,
    output funct3_t              issue_funct3,
    output logic                 issue_funct7_alt,
    output word_t                issue_pc,
    output reg_idx_t             issue_rd, issue_rs1, issue_rs2,
    output word_t                issue_imm
);

    logic found;

    // walk from the head so the first hit is the oldest
    always_comb begin
        int idx;
        found   = 1'b0;
        sel_tag = head_ptr;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            idx = int'(head_ptr) + k;
            if (idx >= ROB_DEPTH) idx = idx - ROB_DEPTH;  // wrap
            if (!found && pending_mask[idx]) begin
                found   = 1'b1;
                sel_tag = rob_tag_t'(idx);
            end
        end
    end

    assign issue_take = found & (~issue_valid | issue_ready);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else if (issue_take) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clk_in) begin
        if (issue_take) begin
            issue_tag        <= sel_tag;
            issue_route      <= sel_route;
            issue_is_jump    <= sel_is_jump;
            issue_op         <= sel_op;
            issue_funct3     <= sel_funct3;
            issue_funct7_alt <= sel_funct7_alt;
            issue_pc         <= sel_pc;
            issue_rd         <= sel_rd;
            issue_rs1        <= sel_rs1;
            issue_rs2        <= sel_rs2;
            issue_imm        <= sel_imm;
        end
    end

endmodule

// ==== design/rob_commit.sv ====
/*
  in-order commit register
  takes the done head and pops it from the store
*/
module rob_commit import rob_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       head_done,
    input  rob_tag_t   head_tag,
    input  dest_kind_e head_kind,
    input  reg_idx_t   head_rd,
    input  word_t      head_value,
    input  logic       head_pc_change,
    input  word_t      head_new_pc,
    output logic       commit_take,
    output logic       commit_valid,
    input  logic       commit_ready,
    output rob_tag_t   commit_tag,
    output dest_kind_e commit_kind,
    output reg_idx_t   commit_rd,
    output word_t      commit_value,
    output logic       commit_pc_change,
    output word_t      commit_new_pc
);

    // free or draining this cycle
    assign commit_take = head_done & (~commit_valid | commit_ready);

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (commit_take) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (commit_take) begin
            commit_tag       <= head_tag;
            commit_kind      <= head_kind;
            commit_rd        <= head_rd;
            commit_value     <= head_value;
            commit_pc_change <= head_pc_change;
            commit_new_pc    <= head_new_pc;  // own pc unless redirected
        end
    end

endmodule

// ==== design/rob_top.sv ====
/*
  reorder buffer top level
  classifier, entry store, issue selector and commit stage
*/
module rob_top import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic       clk_in,
    input  logic       rst_n,
    // allocation
    input  logic       alloc_valid,
    output logic       alloc_ready,
    input  op_major_e  alloc_op,
    input  funct3_t    alloc_funct3,
    input  logic       alloc_funct7_alt,
    input  word_t      alloc_pc,
    input  reg_idx_t   alloc_rd, alloc_rs1, alloc_rs2,
    input  word_t      alloc_imm,
    // issue
    output logic       issue_valid,
    input  logic       issue_ready,
    output rob_tag_t   issue_tag,
    output route_e     issue_route,
    output logic       issue_is_jump,
    output op_major_e  issue_op,
    output funct3_t    issue_funct3,
    output logic       issue_funct7_alt,
    output word_t      issue_pc,
    output reg_idx_t   issue_rd, issue_rs1, issue_rs2,
    output word_t      issue_imm,
    // writeback, always accepted
    input  logic       wb_valid,
    input  rob_tag_t   wb_tag,
    input  word_t      wb_value,
    input  logic       wb_pc_change,
    input  word_t      wb_new_pc,
    // commit
    output logic       commit_valid,
    input  logic       commit_ready,
    output rob_tag_t   commit_tag,
    output dest_kind_e commit_kind,
    output reg_idx_t   commit_rd,
    output word_t      commit_value,
    output logic       commit_pc_change,
    output word_t      commit_new_pc
);

    dest_kind_e           kind;
    route_e               route;
    logic                 is_jump, early_done;
    word_t                early_value;
    logic [ROB_DEPTH-1:0] pending_mask;
    rob_tag_t             head_ptr, sel_tag;
    logic                 issue_take;
    op_major_e            sel_op;
    funct3_t              sel_funct3;
    logic                 sel_funct7_alt;
    word_t                sel_pc, sel_imm;
    reg_idx_t             sel_rd, sel_rs1, sel_rs2;
    route_e               sel_route;
    logic                 sel_is_jump;
    logic                 head_done, head_pc_change, commit_take;
    rob_tag_t             head_tag;
    dest_kind_e           head_kind;
    reg_idx_t             head_rd;
    word_t                head_value, head_new_pc;

    rob_classify classify_i (
        .op          (alloc_op),
        .pc          (alloc_pc),
        .imm         (alloc_imm),
        .kind        (kind),
        .route       (route),
        .is_jump     (is_jump),
        .early_done  (early_done),
        .early_value (early_value)
    );

    rob_entry_store #(.ROB_DEPTH(ROB_DEPTH)) store_i (.*);

    rob_issue_select #(.ROB_DEPTH(ROB_DEPTH)) issue_i (.*);

    rob_commit commit_i (.*);

endmodule

// ==== include/rob_tb_tasks.svh ====
/*
  typed compare tasks for the reorder buffer testbench
  Fibonacci LFSR used for stalls and writeback hold-back
*/
`ifndef ROB_TB_TASKS_SVH
`define ROB_TB_TASKS_SVH

task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_kind(input string name, input dest_kind_e got, input dest_kind_e exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_route(input string name, input route_e got, input route_e exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_funct3(input string name, input funct3_t got, input funct3_t exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_op(input string name, input op_major_e got, input op_major_e exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
        abort_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
endtask

// taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);  // one step per bit
    return lfsr_state[0];
endfunction

`endif

// ==== test/rob_tb.sv ====
/*
  reorder buffer testbench top
  golden-file allocation driver, issue/writeback/commit scoreboard
  stall hold checks and a cycle watchdog
*/
module rob_tb import rob_pkg::*; ();

    localparam int DEPTH  = 16;
    localparam int N_REC  = 20;
    localparam int FIELDS = 8;  // words per golden record

    logic       clk_in;
    logic       rst_n;
    logic       alloc_valid, alloc_ready;
    op_major_e  alloc_op;
    funct3_t    alloc_funct3;
    logic       alloc_funct7_alt;
    word_t      alloc_pc, alloc_imm;
    reg_idx_t   alloc_rd, alloc_rs1, alloc_rs2;
    logic       issue_valid, issue_ready, issue_is_jump, issue_funct7_alt;
    rob_tag_t   issue_tag;
    route_e     issue_route;
    op_major_e  issue_op;
    funct3_t    issue_funct3;
    word_t      issue_pc, issue_imm;
    reg_idx_t   issue_rd, issue_rs1, issue_rs2;
    logic       wb_valid, wb_pc_change;
    rob_tag_t   wb_tag;
    word_t      wb_value, wb_new_pc;
    logic       commit_valid, commit_ready, commit_pc_change;
    rob_tag_t   commit_tag;
    dest_kind_e commit_kind;
    reg_idx_t   commit_rd;
    word_t      commit_value, commit_new_pc;

    logic [31:0] golden [N_REC*FIELDS];
    logic [31:0] lfsr_state = 32'h30f6;
    int          exp_issue_q[$];
    int          exp_commit_q[$];
    int          wb_backlog_q[$];      // issued, not yet written back
    int          commit_count = 0;
    logic [1:0]  hold_target = 2'd2;
    logic        wb_enable;
    logic        issue_stalled = 1'b0;
    logic        commit_stalled = 1'b0;
    rob_tag_t    stall_issue_tag, stall_commit_tag;
    word_t       stall_issue_pc, stall_issue_imm;
    word_t       stall_commit_value, stall_commit_new_pc;

    `include "rob_tb_tasks.svh"

    rob_top #(.ROB_DEPTH(DEPTH)) rob_top_i (.*);

    always #2 clk_in = ~clk_in;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic is_early(input op_major_e op);
        return (op == op_lui) || (op == op_auipc);
    endfunction

    function automatic dest_kind_e exp_kind(input op_major_e op);
        case (op)
            op_jal, op_jalr:   return dest_jump_link;
            op_branch:         return dest_branch;
            op_load, op_store: return dest_mem;
            default:           return dest_reg;
        endcase
    endfunction

    function automatic route_e exp_route(input op_major_e op);
        case (op)
            op_load, op_store:          return route_lsu;
            op_jal, op_jalr, op_branch: return route_branch;
            default:                    return route_alu;
        endcase
    endfunction

    task automatic check_issue(input int idx);
        op_major_e op;
        op = op_major_e'(golden[idx*FIELDS][6:0]);
        if (is_early(issue_op))
            abort_run("a LUI or AUIPC entry showed up on the issue port");
        check_tag("issue_tag", issue_tag, rob_tag_t'(idx % DEPTH));
        check_route("issue_route", issue_route, exp_route(op));
        check_bit("issue_is_jump", issue_is_jump, (op == op_jal) || (op == op_jalr));
        check_op("issue_op", issue_op, op);
        check_funct3("issue_funct3", issue_funct3, golden[idx*FIELDS+1][2:0]);
        check_bit("issue_funct7_alt", issue_funct7_alt, idx[0]);
        check_word("issue_pc", issue_pc, golden[idx*FIELDS+2]);
        check_reg("issue_rd", issue_rd, golden[idx*FIELDS+3][4:0]);
        check_reg("issue_rs1", issue_rs1, reg_idx_t'(idx*3 + 1));
        check_reg("issue_rs2", issue_rs2, reg_idx_t'(idx*7 + 2));
        check_word("issue_imm", issue_imm, golden[idx*FIELDS+4]);
    endtask

    task automatic check_commit(input int idx);
        op_major_e  op;
        dest_kind_e kind;
        word_t      pc, imm, value;
        logic       redirect;
        op   = op_major_e'(golden[idx*FIELDS][6:0]);
        kind = exp_kind(op);
        pc   = golden[idx*FIELDS+2];
        imm  = golden[idx*FIELDS+4];
        value = (op == op_lui) ? imm : (op == op_auipc) ? pc + imm : golden[idx*FIELDS+5];
        // only branches and jumps keep the writeback redirect
        redirect = ((kind == dest_branch) || (kind == dest_jump_link)) &&
                   golden[idx*FIELDS+6][0];
        check_tag("commit_tag", commit_tag, rob_tag_t'(idx % DEPTH));
        check_kind("commit_kind", commit_kind, kind);
        check_reg("commit_rd", commit_rd, golden[idx*FIELDS+3][4:0]);
        check_word("commit_value", commit_value, value);
        check_bit("commit_pc_change", commit_pc_change, redirect);
        check_word("commit_new_pc", commit_new_pc, redirect ? golden[idx*FIELDS+7] : pc);
    endtask

    always @(posedge clk_in) begin : scoreboard
        int idx;
        if (rst_n) begin
            if (issue_stalled) begin  // payload frozen under back-pressure
                check_bit("issue_valid", issue_valid, 1'b1);
                check_tag("issue_tag", issue_tag, stall_issue_tag);
                check_word("issue_pc", issue_pc, stall_issue_pc);
                check_word("issue_imm", issue_imm, stall_issue_imm);
            end
            if (issue_valid && issue_ready) begin
                if (exp_issue_q.size() == 0)
                    abort_run("issue handshake while no instruction was waiting to issue");
                idx = exp_issue_q.pop_front();
                check_issue(idx);
                wb_backlog_q.push_back(idx);
            end
            issue_stalled   = issue_valid && !issue_ready;
            stall_issue_tag = issue_tag;
            stall_issue_pc  = issue_pc;
            stall_issue_imm = issue_imm;

            // newest first, so writebacks arrive out of order
            if (wb_enable && wb_backlog_q.size() > 0 &&
                (wb_backlog_q.size() > int'(hold_target) || !issue_valid)) begin
                idx = wb_backlog_q.pop_back();
                wb_valid     <= 1'b1;
                wb_tag       <= rob_tag_t'(idx % DEPTH);
                wb_value     <= golden[idx*FIELDS+5];
                wb_pc_change <= golden[idx*FIELDS+6][0];
                wb_new_pc    <= golden[idx*FIELDS+7];
                if (wb_backlog_q.size() == 0) hold_target = {take_bit(), take_bit()};
            end else begin
                wb_valid <= 1'b0;
            end

            if (commit_stalled) begin
                check_bit("commit_valid", commit_valid, 1'b1);
                check_tag("commit_tag", commit_tag, stall_commit_tag);
                check_word("commit_value", commit_value, stall_commit_value);
                check_word("commit_new_pc", commit_new_pc, stall_commit_new_pc);
            end
            if (commit_valid && commit_ready) begin
                if (exp_commit_q.size() == 0)
                    abort_run("commit handshake while no entry was expected to commit");
                idx = exp_commit_q.pop_front();
                check_commit(idx);
                commit_count <= commit_count + 1;
            end
            commit_stalled      = commit_valid && !commit_ready;
            stall_commit_tag    = commit_tag;
            stall_commit_value  = commit_value;
            stall_commit_new_pc = commit_new_pc;

            issue_ready  <= take_bit() | take_bit();  // low about a quarter of cycles
            commit_ready <= take_bit() | take_bit();
        end
    end

    initial begin : alloc_driver
        op_major_e op;
        clk_in           = 1'b0;
        rst_n            = 1'b0;
        alloc_valid      = 1'b0;
        alloc_op         = op_imm;
        alloc_funct3     = '0;
        alloc_funct7_alt = 1'b0;
        alloc_pc         = '0;
        alloc_rd         = '0;
        alloc_rs1        = '0;
        alloc_rs2        = '0;
        alloc_imm        = '0;
        issue_ready      = 1'b0;
        commit_ready     = 1'b0;
        wb_valid         = 1'b0;
        wb_tag           = '0;
        wb_value         = '0;
        wb_pc_change     = 1'b0;
        wb_new_pc        = '0;
        wb_enable        = 1'b0;  // held off until the buffer has filled
        $readmemh("test/rob_golden.txt", golden);
        if ($isunknown(golden[N_REC*FIELDS-1]))
            abort_run("golden file is missing or has too few records");
        repeat (3) @(posedge clk_in);
        rst_n <= 1'b1;
        @(posedge clk_in);
        check_bit("alloc_ready", alloc_ready, 1'b1);
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("commit_valid", commit_valid, 1'b0);

        for (int i = 0; i < N_REC; i++) begin
            op = op_major_e'(golden[i*FIELDS][6:0]);
            alloc_valid      <= 1'b1;
            alloc_op         <= op;
            alloc_funct3     <= golden[i*FIELDS+1][2:0];
            alloc_funct7_alt <= i[0];
            alloc_pc         <= golden[i*FIELDS+2];
            alloc_rd         <= golden[i*FIELDS+3][4:0];
            alloc_rs1        <= reg_idx_t'(i*3 + 1);
            alloc_rs2        <= reg_idx_t'(i*7 + 2);
            alloc_imm        <= golden[i*FIELDS+4];
            do @(posedge clk_in); while (!alloc_ready);
            exp_commit_q.push_back(i);
            if (!is_early(op)) exp_issue_q.push_back(i);
            if (i == DEPTH - 1) begin
                // full with nothing committed
                alloc_valid <= 1'b0;
                @(posedge clk_in);
                check_bit("alloc_ready", alloc_ready, 1'b0);
                wb_enable <= 1'b1;
                do @(posedge clk_in); while (!alloc_ready);
            end
        end
        alloc_valid <= 1'b0;

        while (commit_count < N_REC) @(posedge clk_in);
        if (exp_issue_q.size() == 0 && exp_commit_q.size() == 0 &&
            wb_backlog_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("entries were left over after the last commit");
        end
    end

    initial begin : watchdog
        repeat (N_REC * 200) @(posedge clk_in);
        abort_run("timeout, the run did not finish within the cycle limit");
    end

endmodule

// ==== test/rob_golden.txt ====
// each record is op funct3 pc rd imm wb_value wb_flag wb_new_pc
// writeback fields are not used for LUI (37) and AUIPC (17)
13 0 00001000 01 00000005 00000006 0 00000000
33 0 00001004 02 00000000 0000000b 0 00000000
37 0 00001008 03 12345000 00000000 0 00000000
03 2 0000100c 04 00000010 deadbeef 0 00000000
23 2 00001010 00 00000014 00000000 1 00002000
63 1 00001014 00 00000020 00000000 1 00001034
17 0 00001018 05 00010000 00000000 0 00000000
6f 0 0000101c 01 00000040 00001020 1 0000105c
33 5 00001020 06 00000000 00000400 0 00000000
67 0 00001024 07 00000008 00001028 1 00000108
63 0 00001028 00 fffffff0 00000000 0 00001018
13 7 0000102c 08 000000ff 0000a5a5 1 00003000
37 0 00001030 09 fffff000 00000000 0 00000000
03 4 00001034 0a 00000004 000000aa 0 00000000
33 0 00001038 0b 00000000 12345678 0 00000000
13 1 0000103c 0c 00000003 00000050 0 00000000
17 0 00001040 0d fffff000 00000000 0 00000000
23 0 00001044 00 00000008 00000000 0 00000000
63 5 00001048 00 00000010 00000000 1 00001058
33 0 0000104c 0e 00000000 80000000 0 00000000

// ==== tb.f ====
+incdir+include
design/rob_pkg.sv
design/rob_classify.sv
design/rob_entry_store.sv
design/rob_issue_select.sv
design/rob_commit.sv
design/rob_top.sv
test/rob_tb.sv

// ==== Makefile ====
# Verilator flow for the reorder buffer testbench
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
